//--- verilog/evc_defines.svh
// ====================================================================
// sizes and register map of the event controller
// the register map assumes exactly four selected outputs
// addresses are byte addresses of 32-bit words
// ====================================================================
`ifndef EVC_DEFINES_SVH
`define EVC_DEFINES_SVH

// event inputs, one queue each
`define EVC_EVCNT 16

// error level inputs
`define EVC_ERRCNT 8

// selectable event outputs
`define EVC_SELCNT 4

// pending counter width, saturates at 2**EVC_QCW-1
`define EVC_QCW 3

// event index of selected output 0..3
`define EVC_A_SEL0 8'h00
`define EVC_A_SEL1 8'h04
`define EVC_A_SEL2 8'h08
`define EVC_A_SEL3 8'h0C

// enables of the selected outputs
`define EVC_A_SELEN 8'h10

// stream enables, one per event
`define EVC_A_IFEN 8'h14

// error enables for the nmi
`define EVC_A_ERREN 8'h18

// sticky overflow flags, write one to clear
`define EVC_A_OVF 8'h1C

// raw error inputs, read only
`define EVC_A_ERRIN 8'h20

`endif

//--- verilog/evc_pkg.sv
// ====================================================================
// types shared by the event controller blocks
// widths follow the macros in evc_defines.svh
// ====================================================================
`include "evc_defines.svh"

package evc_pkg;

    // one bit per event input
    typedef logic [`EVC_EVCNT-1:0] ev_vec_t;

    // event number
    typedef logic [$clog2(`EVC_EVCNT)-1:0] ev_idx_t;

    // one bit per error input
    typedef logic [`EVC_ERRCNT-1:0] err_vec_t;

    // register port
    typedef logic [7:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // pending events in one queue
    typedef logic [`EVC_QCW-1:0] qcnt_t;

    // stream output state machine
    typedef enum logic {
        ST_IDLE,
        ST_OFFER
    } stream_state_t;

endpackage

//--- verilog/evc_cfg_if.sv
// ====================================================================
// configuration from the register block to routing and stream logic
// ovf_set carries one-cycle pulses back to the sticky flags
// ====================================================================
`timescale 1ns/10ps
`include "evc_defines.svh"

interface evc_cfg_if;
    import evc_pkg::*;

    // event index per selected output
    ev_idx_t [`EVC_SELCNT-1:0] sel;
    logic    [`EVC_SELCNT-1:0] sel_en;

    // per event stream enable
    ev_vec_t if_en;

    // error mask for the nmi
    err_vec_t err_en;

    // overflow pulses from the queues
    ev_vec_t ovf_set;

    modport regs (
        output sel,
        output sel_en,
        output if_en,
        output err_en,
        input  ovf_set
    );

    modport route (
        input sel,
        input sel_en,
        input err_en
    );

    // used by the top level around the queue array
    modport stream (
        input  if_en,
        output ovf_set
    );

endinterface

//--- verilog/evc_regs.sv
// ====================================================================
// control registers with a combinational read port
// unmapped addresses read zero and ignore writes
// overflow flags are sticky, a set wins over a clear in one cycle
// ====================================================================
`timescale 1ns/10ps
`include "evc_defines.svh"

module evc_regs (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               reg_we_i,
    input  evc_pkg::reg_addr_t reg_addr_i,
    input  evc_pkg::reg_data_t reg_wdata_i,
    output evc_pkg::reg_data_t reg_rdata_o,
    input  evc_pkg::err_vec_t  err_i,
    evc_cfg_if.regs            cfg,
    output logic               ovf_any_o
);
    import evc_pkg::*;

    ev_idx_t [`EVC_SELCNT-1:0] sel_q;
    logic    [`EVC_SELCNT-1:0] sel_en_q;
    ev_vec_t                   if_en_q;
    err_vec_t                  err_en_q;
    ev_vec_t                   ovf_q;
    ev_vec_t                   ovf_clr;

    // write decode
    always_ff @(posedge clk) begin
        if (rst_i) begin
            sel_q    <= '0;
            sel_en_q <= '0;
            if_en_q  <= '0;
            err_en_q <= '0;
        end else if (reg_we_i) begin
            case (reg_addr_i)
                `EVC_A_SEL0:  sel_q[0] <= ev_idx_t'(reg_wdata_i);
                `EVC_A_SEL1:  sel_q[1] <= ev_idx_t'(reg_wdata_i);
                `EVC_A_SEL2:  sel_q[2] <= ev_idx_t'(reg_wdata_i);
                `EVC_A_SEL3:  sel_q[3] <= ev_idx_t'(reg_wdata_i);
                `EVC_A_SELEN: sel_en_q <= reg_wdata_i[`EVC_SELCNT-1:0];
                `EVC_A_IFEN:  if_en_q  <= ev_vec_t'(reg_wdata_i);
                `EVC_A_ERREN: err_en_q <= err_vec_t'(reg_wdata_i);
                default: ;
            endcase
        end
    end

    // write one to clear on the flag address
    assign ovf_clr = (reg_we_i && reg_addr_i == `EVC_A_OVF) ? ev_vec_t'(reg_wdata_i) : '0;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ovf_q <= '0;
        end else begin
            ovf_q <= (ovf_q & ~ovf_clr) | cfg.ovf_set;
        end
    end

    assign ovf_any_o = |ovf_q;

    assign cfg.sel    = sel_q;
    assign cfg.sel_en = sel_en_q;
    assign cfg.if_en  = if_en_q;
    assign cfg.err_en = err_en_q;

    // read mux
    always_comb begin
        reg_rdata_o = '0;
        case (reg_addr_i)
            `EVC_A_SEL0:  reg_rdata_o = reg_data_t'(sel_q[0]);
            `EVC_A_SEL1:  reg_rdata_o = reg_data_t'(sel_q[1]);
            `EVC_A_SEL2:  reg_rdata_o = reg_data_t'(sel_q[2]);
            `EVC_A_SEL3:  reg_rdata_o = reg_data_t'(sel_q[3]);
            `EVC_A_SELEN: reg_rdata_o = reg_data_t'(sel_en_q);
            `EVC_A_IFEN:  reg_rdata_o = reg_data_t'(if_en_q);
            `EVC_A_ERREN: reg_rdata_o = reg_data_t'(err_en_q);
            `EVC_A_OVF:   reg_rdata_o = reg_data_t'(ovf_q);
            `EVC_A_ERRIN: reg_rdata_o = reg_data_t'(err_i);
            default:      reg_rdata_o = '0;
        endcase
    end

endmodule

//--- verilog/evc_route.sv
// ====================================================================
// interrupt mirror and selected outputs, one cycle after ev_i
// nmi_o is combinational from err_i with no register
// ====================================================================
`timescale 1ns/10ps
`include "evc_defines.svh"

module evc_route (
    input  logic                    clk,
    input  logic                    rst_i,
    input  evc_pkg::ev_vec_t        ev_i,
    input  evc_pkg::err_vec_t       err_i,
    evc_cfg_if.route                cfg,
    output evc_pkg::ev_vec_t        irq_o,
    output logic [`EVC_SELCNT-1:0]  ev_sel_o,
    output logic                    nmi_o
);
    import evc_pkg::*;

    ev_vec_t                 irq_q;
    logic [`EVC_SELCNT-1:0]  sel_q;
    logic [`EVC_SELCNT-1:0]  sel_d;

    // pick one event per output and mask with its enable
    always_comb begin
        for (int n = 0; n < `EVC_SELCNT; n++) begin
            sel_d[n] = cfg.sel_en[n] & ev_i[cfg.sel[n]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            irq_q <= '0;
            sel_q <= '0;
        end else begin
            irq_q <= ev_i;
            sel_q <= sel_d;
        end
    end

    assign irq_o    = irq_q;
    assign ev_sel_o = sel_q;

    // masked error levels
    assign nmi_o = |(err_i & cfg.err_en);

endmodule

//--- verilog/evc_event_queue.sv
// ====================================================================
// pending counter for one event, saturates at full count
// ovf_o pulses one cycle after an event is dropped
// ====================================================================
`timescale 1ns/10ps

module evc_event_queue (
    input  logic clk,
    input  logic rst_i,
    input  logic event_i,
    input  logic ack_i,
    output logic req_o,
    output logic ovf_o
);
    import evc_pkg::*;

    qcnt_t cnt_q;
    logic  full;
    logic  drop;

    assign full = &cnt_q;

    // an ack frees a slot, so only a lone event at full is lost
    assign drop = event_i & ~ack_i & full;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            cnt_q <= '0;
            ovf_o <= 1'b0;
        end else begin
            ovf_o <= drop;
            if (event_i && !ack_i && !full) begin
                cnt_q <= cnt_q + 1'b1;
            end else if (ack_i && !event_i && cnt_q != '0) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    assign req_o = (cnt_q != '0);

endmodule

//--- verilog/evc_arbiter.sv
// ====================================================================
// round-robin arbiter, search starts at the pointer and wraps
// the pointer moves to one past the winner on load_i
// ====================================================================
`timescale 1ns/10ps

module evc_arbiter (
    input  logic             clk,
    input  logic             rst_i,
    input  evc_pkg::ev_vec_t req_i,
    input  logic             load_i,
    output evc_pkg::ev_vec_t grant_o,
    output evc_pkg::ev_idx_t grant_idx_o
);
    import evc_pkg::*;

    localparam int N = $bits(ev_vec_t);

    ev_idx_t ptr_q;
    logic    found;

    always_comb begin
        ev_idx_t cand;
        found       = 1'b0;
        grant_idx_o = '0;
        for (int i = 0; i < N; i++) begin
            cand = ev_idx_t'((int'(ptr_q) + i) % N);
            if (!found && req_i[cand]) begin
                found       = 1'b1;
                grant_idx_o = cand;
            end
        end
        grant_o = ev_vec_t'(found) << grant_idx_o;
    end

    // the winner gets lowest priority next round
    always_ff @(posedge clk) begin
        if (rst_i) begin
            ptr_q <= '0;
        end else if (load_i && found) begin
            ptr_q <= ev_idx_t'((int'(grant_idx_o) + 1) % N);
        end
    end

endmodule

//--- verilog/evc_stream_fsm.sv
// ====================================================================
// offers one event number at a time on a valid/ready output
// data and grant are held while the sink stalls
// at most one message every two cycles
// ====================================================================
`timescale 1ns/10ps

module evc_stream_fsm (
    input  logic             clk,
    input  logic             rst_i,
    input  evc_pkg::ev_vec_t req_i,
    input  evc_pkg::ev_vec_t grant_i,
    input  evc_pkg::ev_idx_t grant_idx_i,
    output logic             load_o,
    output evc_pkg::ev_vec_t ack_o,
    output logic             ifev_vld_o,
    output evc_pkg::ev_idx_t ifev_dat_o,
    input  logic             ifev_rdy_i
);
    import evc_pkg::*;

    stream_state_t state_q;
    stream_state_t state_d;
    ev_idx_t       idx_q;
    ev_vec_t       gnt_q;
    logic          any_req;
    logic          accept;

    assign any_req = |req_i;
    assign accept  = (state_q == ST_OFFER) && ifev_rdy_i;

    // capture the winner when leaving idle
    assign load_o = (state_q == ST_IDLE) && any_req;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (any_req) begin
                    state_d = ST_OFFER;
                end
            end
            ST_OFFER: begin
                if (ifev_rdy_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // held stable through back-pressure
    always_ff @(posedge clk) begin
        if (load_o) begin
            idx_q <= grant_idx_i;
            gnt_q <= grant_i;
        end
    end

    assign ifev_vld_o = (state_q == ST_OFFER);
    assign ifev_dat_o = idx_q;

    // one ack to the served queue on acceptance
    assign ack_o = accept ? gnt_q : '0;

endmodule

//--- verilog/evc_top.sv
// ====================================================================
// event controller top level, single clock domain
// events reach the stream queues only when their enable is set
// ====================================================================
`timescale 1ns/10ps
`include "evc_defines.svh"

module evc_top (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   reg_we_i,
    input  evc_pkg::reg_addr_t     reg_addr_i,
    input  evc_pkg::reg_data_t     reg_wdata_i,
    output evc_pkg::reg_data_t     reg_rdata_o,
    input  evc_pkg::ev_vec_t       ev_i,
    input  evc_pkg::err_vec_t      err_i,
    output evc_pkg::ev_vec_t       irq_o,
    output logic [`EVC_SELCNT-1:0] ev_sel_o,
    output logic                   nmi_o,
    output logic                   ifev_vld_o,
    output evc_pkg::ev_idx_t       ifev_dat_o,
    input  logic                   ifev_rdy_i,
    output logic                   ifev_err_o
);
    import evc_pkg::*;

    ev_vec_t req;
    ev_vec_t ack;
    ev_vec_t ovf;
    ev_vec_t grant;
    ev_idx_t grant_idx;
    logic    load;

    evc_cfg_if cfg ();

    evc_regs evc_regs_i (
        .clk         (clk),
        .rst_i       (rst_i),
        .reg_we_i    (reg_we_i),
        .reg_addr_i  (reg_addr_i),
        .reg_wdata_i (reg_wdata_i),
        .reg_rdata_o (reg_rdata_o),
        .err_i       (err_i),
        .cfg         (cfg.regs),
        .ovf_any_o   (ifev_err_o)
    );

    evc_route evc_route_i (
        .clk      (clk),
        .rst_i    (rst_i),
        .ev_i     (ev_i),
        .err_i    (err_i),
        .cfg      (cfg.route),
        .irq_o    (irq_o),
        .ev_sel_o (ev_sel_o),
        .nmi_o    (nmi_o)
    );

    // one pending counter per event
    for (genvar j = 0; j < `EVC_EVCNT; j++) begin : g_queue
        evc_event_queue evc_event_queue_i (
            .clk     (clk),
            .rst_i   (rst_i),
            .event_i (ev_i[j] & cfg.if_en[j]),
            .ack_i   (ack[j]),
            .req_o   (req[j]),
            .ovf_o   (ovf[j])
        );
    end

    // overflow pulses back to the sticky flags
    assign cfg.ovf_set = ovf;

    evc_arbiter evc_arbiter_i (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_i       (req),
        .load_i      (load),
        .grant_o     (grant),
        .grant_idx_o (grant_idx)
    );

    evc_stream_fsm evc_stream_fsm_i (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_i       (req),
        .grant_i     (grant),
        .grant_idx_i (grant_idx),
        .load_o      (load),
        .ack_o       (ack),
        .ifev_vld_o  (ifev_vld_o),
        .ifev_dat_o  (ifev_dat_o),
        .ifev_rdy_i  (ifev_rdy_i)
    );

endmodule

//--- bench/evc_asserts.sv
// ======================================================================
// protocol checks, bound once to the stream FSM and once to the registers
// ports that do not exist in a target are tied to zero in its bind
// ======================================================================
`timescale 1ns/10ps

module evc_asserts (
    input logic             clk,
    input logic             rst_i,
    input logic             vld_i,
    input logic             rdy_i,
    input evc_pkg::ev_idx_t dat_i,
    input evc_pkg::ev_vec_t ack_i,
    input evc_pkg::ev_vec_t flag_i,
    input evc_pkg::ev_vec_t flag_clr_i
);
    import evc_pkg::*;

    // offer held through back-pressure
    assert property (@(posedge clk) disable iff (rst_i)
        vld_i && !rdy_i |=> vld_i && $stable(dat_i))
        else $error("stream data changed while stalled");

    assert property (@(posedge clk) disable iff (rst_i) $onehot0(ack_i))
        else $error("more than one queue acknowledged");

    // an ack goes out exactly when a message is accepted
    assert property (@(posedge clk) disable iff (rst_i)
        (ack_i != '0) == (vld_i && rdy_i))
        else $error("ack does not match an accepted message");

    assert property (@(posedge clk) rst_i |=> !vld_i)
        else $error("valid high right after reset");

    // a sticky flag only falls when a write of one cleared it
    assert property (@(posedge clk) disable iff (rst_i)
        (($past(flag_i) & ~flag_i & ~$past(flag_clr_i)) == '0))
        else $error("overflow flag cleared without a write");

endmodule

bind evc_stream_fsm evc_asserts evc_asserts_fsm_i (
    .clk        (clk),
    .rst_i      (rst_i),
    .vld_i      (ifev_vld_o),
    .rdy_i      (ifev_rdy_i),
    .dat_i      (ifev_dat_o),
    .ack_i      (ack_o),
    .flag_i     (16'h0000),
    .flag_clr_i (16'h0000)
);

bind evc_regs evc_asserts evc_asserts_regs_i (
    .clk        (clk),
    .rst_i      (rst_i),
    .vld_i      (1'b0),
    .rdy_i      (1'b0),
    .dat_i      (4'h0),
    .ack_i      (16'h0000),
    .flag_i     (ovf_q),
    .flag_clr_i (ovf_clr)
);

//--- bench/evc_tb.sv
// ======================================================================
// testbench for evc_top, commands come from bench/evc_patterns.txt
// run from the project root; a reference model checks every cycle
// ======================================================================
`timescale 1ns/10ps
`include "evc_defines.svh"

module evc_tb;
    import evc_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DELAY = 2;

    logic                   clk;
    logic                   rst_i;
    logic                   reg_we_i;
    reg_addr_t              reg_addr_i;
    reg_data_t              reg_wdata_i;
    reg_data_t              reg_rdata_o;
    ev_vec_t                ev_i;
    err_vec_t               err_i;
    ev_vec_t                irq_o;
    logic [`EVC_SELCNT-1:0] ev_sel_o;
    logic                   nmi_o;
    logic                   ifev_vld_o;
    ev_idx_t                ifev_dat_o;
    logic                   ifev_rdy_i;
    logic                   ifev_err_o;

    // random streams for event stimulus and for ready
    int seed;
    int rdy_seed;
    int rdy_mode;

    // parsed command lines
    int          q_test[$];
    logic [31:0] q_op[$];
    logic [31:0] q_arg[$];
    logic [31:0] q_val[$];
    int          n_cmds;

    int test_errs;
    int total_errs;
    int n_checks;
    int n_tests;
    int n_failed;

    // reference model state
    int                     m_cnt[`EVC_EVCNT];
    ev_vec_t                m_flag;
    ev_vec_t                m_ovf_pulse;
    ev_vec_t                m_ifen;
    err_vec_t               m_erren;
    ev_idx_t                m_sel[`EVC_SELCNT];
    logic [`EVC_SELCNT-1:0] m_selen;
    logic [`EVC_SELCNT-1:0] exp_sel;
    ev_vec_t                prev_ev;
    logic                   m_offer;
    ev_idx_t                m_idx;
    int                     m_ptr;
    int                     msgs;

    evc_top evc_top_i (
        .clk         (clk),
        .rst_i       (rst_i),
        .reg_we_i    (reg_we_i),
        .reg_addr_i  (reg_addr_i),
        .reg_wdata_i (reg_wdata_i),
        .reg_rdata_o (reg_rdata_o),
        .ev_i        (ev_i),
        .err_i       (err_i),
        .irq_o       (irq_o),
        .ev_sel_o    (ev_sel_o),
        .nmi_o       (nmi_o),
        .ifev_vld_o  (ifev_vld_o),
        .ifev_dat_o  (ifev_dat_o),
        .ifev_rdy_i  (ifev_rdy_i),
        .ifev_err_o  (ifev_err_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
        n_checks++;
        assert (exp == act) else begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            test_errs++;
        end
    endtask

    task automatic load_patterns();
        int          fd;
        int          n;
        int          t;
        string       line;
        logic [31:0] op;
        logic [31:0] arg;
        logic [31:0] val;
        fd = $fopen("bench/evc_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file bench/evc_patterns.txt");
            test_errs++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%d %h %h %h", t, op, arg, val);
                    if (n == 4) begin
                        q_test.push_back(t);
                        q_op.push_back(op);
                        q_arg.push_back(arg);
                        q_val.push_back(val);
                    end
                end
            end
            $fclose(fd);
        end
        n_cmds = q_test.size();
    endtask

    // waits until the model has no pending event and no open offer
    task automatic drain(input logic [31:0] exp_msgs, input int max_cycles);
        int   waited;
        logic done;
        done   = 1'b0;
        waited = 0;
        while (!done && waited < max_cycles) begin
            @(posedge clk);
            waited++;
            done = !m_offer;
            for (int j = 0; j < `EVC_EVCNT; j++) begin
                if (m_cnt[j] != 0) begin
                    done = 1'b0;
                end
            end
        end
        assert (done) else begin
            $display("stream did not drain within %0d cycles", max_cycles);
            test_errs++;
        end
        if (exp_msgs != 32'hffff) begin
            check_val("message count", exp_msgs, 32'(msgs));
        end
        msgs = 0;
    endtask

    task automatic run_cmd(input logic [31:0] op, input logic [31:0] arg,
                           input logic [31:0] val);
        int rnd;
        case (op)
            32'd1: begin
                @(posedge clk);
                #DRIVE_DELAY;
                reg_we_i    = 1'b1;
                reg_addr_i  = reg_addr_t'(arg);
                reg_wdata_i = val;
                @(posedge clk);
                #DRIVE_DELAY;
                reg_we_i = 1'b0;
            end
            32'd2: begin
                @(posedge clk);
                #DRIVE_DELAY;
                reg_addr_i = reg_addr_t'(arg);
                @(negedge clk);
                check_val("reg_rdata_o", val, reg_rdata_o);
            end
            32'd3, 32'd4: begin
                repeat (int'(val)) begin
                    @(posedge clk);
                    #DRIVE_DELAY;
                    rnd  = $random(seed);
                    ev_i = (op == 32'd3) ? ev_vec_t'(arg) : ev_vec_t'(rnd) & ev_vec_t'(arg);
                end
                @(posedge clk);
                #DRIVE_DELAY;
                ev_i = '0;
            end
            32'd5: begin
                @(posedge clk);
                #DRIVE_DELAY;
                err_i = err_vec_t'(val);
            end
            32'd6: rdy_mode = int'(val);
            32'd7: drain(arg, int'(val));
            default: begin
                $display("unknown opcode %0h in the pattern file", op);
                test_errs++;
            end
        endcase
    endtask

    task automatic end_test(input int t);
        n_tests++;
        if (test_errs != 0) begin
            n_failed++;
            $display("test %0d failed with %0d errors", t, test_errs);
        end else begin
            $display("test %0d passed", t);
        end
        total_errs += test_errs;
        test_errs = 0;
    endtask

    // ready source for the stream sink
    initial begin
        int rnd;
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            rnd = $random(rdy_seed);
            if (rdy_mode == 0) begin
                ifev_rdy_i = 1'b0;
            end else if (rdy_mode == 1) begin
                ifev_rdy_i = 1'b1;
            end else begin
                ifev_rdy_i = rnd[0];
            end
        end
    end

    // reference model, evaluated mid-cycle for the coming edge
    always @(negedge clk) begin : model
        ev_vec_t e;
        ev_vec_t drop;
        logic    acc;
        logic    found;
        logic    a;
        int      win;
        int      c;
        if (rst_i) begin
            for (int j = 0; j < `EVC_EVCNT; j++) begin
                m_cnt[j] = 0;
            end
            for (int n = 0; n < `EVC_SELCNT; n++) begin
                m_sel[n] = '0;
            end
            m_flag      = '0;
            m_ovf_pulse = '0;
            m_ifen      = '0;
            m_erren     = '0;
            m_selen     = '0;
            exp_sel     = '0;
            prev_ev     = '0;
            m_offer     = 1'b0;
            m_idx       = '0;
            m_ptr       = 0;
        end else begin
            check_val("irq_o", 32'(prev_ev), 32'(irq_o));
            check_val("ev_sel_o", 32'(exp_sel), 32'(ev_sel_o));
            check_val("nmi_o", 32'(|(err_i & m_erren)), 32'(nmi_o));
            check_val("ifev_err_o", 32'(|m_flag), 32'(ifev_err_o));
            check_val("ifev_vld_o", 32'(m_offer), 32'(ifev_vld_o));
            if (m_offer) begin
                check_val("ifev_dat_o", 32'(m_idx), 32'(ifev_dat_o));
            end
            // handshakes seen at the DUT boundary
            if (ifev_vld_o && ifev_rdy_i) begin
                msgs++;
            end
            prev_ev = ev_i;
            for (int n = 0; n < `EVC_SELCNT; n++) begin
                exp_sel[n] = m_selen[n] & ev_i[m_sel[n]];
            end
            // round-robin winner from the counts before this edge
            acc   = m_offer && ifev_rdy_i;
            found = 1'b0;
            win   = 0;
            for (int i = 0; i < `EVC_EVCNT; i++) begin
                c = (m_ptr + i) % `EVC_EVCNT;
                if (!found && m_cnt[c] != 0) begin
                    found = 1'b1;
                    win   = c;
                end
            end
            if (reg_we_i && reg_addr_i == `EVC_A_OVF) begin
                m_flag = (m_flag & ~ev_vec_t'(reg_wdata_i)) | m_ovf_pulse;
            end else begin
                m_flag = m_flag | m_ovf_pulse;
            end
            e    = ev_i & m_ifen;
            drop = '0;
            for (int j = 0; j < `EVC_EVCNT; j++) begin
                a = acc && int'(m_idx) == j;
                if (e[j] && !a && m_cnt[j] == 7) begin
                    drop[j] = 1'b1;
                end else if (e[j] && !a) begin
                    m_cnt[j] = m_cnt[j] + 1;
                end else if (a && !e[j]) begin
                    m_cnt[j] = m_cnt[j] - 1;
                end
            end
            m_ovf_pulse = drop;
            if (!m_offer && found) begin
                m_offer = 1'b1;
                m_idx   = ev_idx_t'(win);
                m_ptr   = (win + 1) % `EVC_EVCNT;
            end else if (acc) begin
                m_offer = 1'b0;
            end
            if (reg_we_i) begin
                case (reg_addr_i)
                    `EVC_A_SEL0:  m_sel[0] = ev_idx_t'(reg_wdata_i);
                    `EVC_A_SEL1:  m_sel[1] = ev_idx_t'(reg_wdata_i);
                    `EVC_A_SEL2:  m_sel[2] = ev_idx_t'(reg_wdata_i);
                    `EVC_A_SEL3:  m_sel[3] = ev_idx_t'(reg_wdata_i);
                    `EVC_A_SELEN: m_selen  = reg_wdata_i[`EVC_SELCNT-1:0];
                    `EVC_A_IFEN:  m_ifen   = ev_vec_t'(reg_wdata_i);
                    `EVC_A_ERREN: m_erren  = err_vec_t'(reg_wdata_i);
                    default: ;
                endcase
            end
        end
    end

    // watchdog, 200 cycles per command line
    initial begin
        wait (n_cmds > 0);
        repeat (n_cmds * 200) @(posedge clk);
        $display("timeout after %0d cycles, the run did not finish", n_cmds * 200);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        int cur;
        seed        = 32'hf34c6e62;
        rdy_seed    = 32'hf34c6e62;
        rdy_mode    = 0;
        rst_i       = 1'b1;
        reg_we_i    = 1'b0;
        reg_addr_i  = '0;
        reg_wdata_i = '0;
        ev_i        = '0;
        err_i       = '0;
        ifev_rdy_i  = 1'b0;
        msgs        = 0;
        load_patterns();
        repeat (5) @(posedge clk);
        #DRIVE_DELAY;
        rst_i = 1'b0;
        cur = -1;
        for (int i = 0; i < n_cmds; i++) begin
            if (q_test[i] != cur) begin
                if (cur >= 0) begin
                    end_test(cur);
                end
                cur = q_test[i];
            end
            run_cmd(q_op[i], q_arg[i], q_val[i]);
        end
        end_test(cur);
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 n_tests, n_failed, n_checks, total_errs);
        if (n_failed == 0 && total_errs == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- bench/evc_patterns.txt
# columns: test (decimal), opcode, address or event mask, value (all three hex)
# opcodes: 1 write, 2 read-expect, 3 pulse mask for value cycles, 4 random pulses under mask, 5 error level, 6 ready mode (0 low 1 high 2 random), 7 drain (expected messages or ffff, max cycles)
1 1 00 5
1 1 04 a
1 1 08 f
1 1 0c 3
1 1 10 f
1 1 18 3c
1 2 00 5
1 2 0c 3
1 2 10 f
1 2 18 3c
1 2 24 0
1 2 1c 0
1 5 0 a5
1 2 20 a5
2 3 0020 1
2 3 8408 2
2 3 ffff 1
2 3 0800 3
3 5 0 c3
3 5 0 04
3 1 18 80
3 5 0 80
3 5 0 00
4 6 0 1
4 1 14 7fff
4 4 ffff 6
4 7 ffff 320
4 4 ffff 6
4 7 ffff 320
5 6 0 2
5 4 ffff 6
5 7 ffff 320
5 4 0f0f 6
5 7 ffff 320
6 1 14 0008
6 6 0 0
6 3 0008 8
6 2 1c 8
6 6 0 1
6 7 7 100
6 2 1c 8
6 1 1c 8
6 2 1c 0

//--- evc.f
+incdir+verilog
verilog/evc_pkg.sv
verilog/evc_cfg_if.sv
verilog/evc_regs.sv
verilog/evc_route.sv
verilog/evc_event_queue.sv
verilog/evc_arbiter.sv
verilog/evc_stream_fsm.sv
verilog/evc_top.sv
bench/evc_asserts.sv
bench/evc_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the event controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -f evc.f --top-module evc_tb -o evc_sim
./obj_dir/evc_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation ended without a result, see sim.log"
    exit 1
fi
exit 0
